// File: src/lotrTile_defines.svh
// response credit count, target core field bounds, mmio register word offsets
`ifndef LOTR_TILE_DEFINES_SVH
`define LOTR_TILE_DEFINES_SVH

// ============================================================
// local response path
// ============================================================
// local rsp queue depth == credits held by the request filter
`define LOTR_RSP_CREDITS 4

// ============================================================
// address decode
// ============================================================
// top address byte names the target core
`define LOTR_CORE_MSB 31
`define LOTR_CORE_LSB 24

// word offsets inside the mmio window
// offsets 0..5 are the six hex digits
`define LOTR_REG_LED    6
`define LOTR_REG_STATUS 7

`endif

// File: src/lotrRingPkg.sv
// ring opcode enum, requestor layout and the ring message struct
package lotrRingPkg;

    // ============================================================
    // opcodes carried on both rings
    // ============================================================
    typedef enum logic [1:0] {
        RD     = 2'b00, // read request
        WR     = 2'b01, // write request
        RD_RSP = 2'b10, // read response, data is the read value
        WR_RSP = 2'b11  // write response, data echoes the write
    } t_opcode;

    // requestor id, core in the upper 8 bits
    typedef struct packed {
        logic [7:0] core;   // issuing tile
        logic [1:0] thread; // hw thread inside that tile
    } t_requestor;

    // one ring slot, 77 bits
    // same shape for req and rsp rings
    typedef struct packed {
        logic        valid;     // slot occupied
        t_requestor  requestor; // who gets the response
        t_opcode     opcode;
        logic [31:0] address;   // [31:24] target core
        logic [31:0] data;
    } t_ringMsg;

endpackage

// File: src/lotrMmioPkg.sv
// mmio register index enum, display output struct, hex to 7-seg decoder
`include "lotrTile_defines.svh"
package lotrMmioPkg;

    // register index, taken from address[4:2]
    typedef enum logic [2:0] {
        REG_DIG0   = 3'd0,
        REG_DIG1   = 3'd1,
        REG_DIG2   = 3'd2,
        REG_DIG3   = 3'd3,
        REG_DIG4   = 3'd4,
        REG_DIG5   = 3'd5,
        REG_LED    = 3'(`LOTR_REG_LED),
        REG_STATUS = 3'(`LOTR_REG_STATUS) // read only
    } t_mmioReg;

    // board outputs, seg[i] drives HEXi
    typedef struct packed {
        logic [5:0][6:0] seg; // active low, bit0 = segment a
        logic [6:0]      led;
    } t_display;

    // DE10-Lite order {g,f,e,d,c,b,a}, active low
    function automatic logic [6:0] hexToSeg(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'h0: pattern = 7'b1000000;
            4'h1: pattern = 7'b1111001;
            4'h2: pattern = 7'b0100100;
            4'h3: pattern = 7'b0110000;
            4'h4: pattern = 7'b0011001;
            4'h5: pattern = 7'b0010010;
            4'h6: pattern = 7'b0000010;
            4'h7: pattern = 7'b1111000;
            4'h8: pattern = 7'b0000000;
            4'h9: pattern = 7'b0010000;
            4'hA: pattern = 7'b0001000;
            4'hB: pattern = 7'b0000011; // lower case b
            4'hC: pattern = 7'b1000110;
            4'hD: pattern = 7'b0100001; // lower case d
            4'hE: pattern = 7'b0000110;
            default: pattern = 7'b0001110; // F
        endcase
        return pattern;
    endfunction

endpackage

// File: src/ringReqFilter.sv
// request ring stop: two stage pipe, local request split, response credit counter
`include "lotrTile_defines.svh"
module ringReqFilter
    import lotrRingPkg::*;
(
    input  logic       QClk,
    input  logic       rst,
    input  logic [7:0] coreId,       // this tile
    input  t_ringMsg   ringReqIn,
    input  logic       creditReturn, // one pulse per local rsp sent
    output t_ringMsg   ringReqOut,
    output t_ringMsg   localReq      // to mmio, valid Q501H
);

    localparam int CNT_W = $clog2(`LOTR_RSP_CREDITS + 1);

    t_ringMsg         reqQ501H;   // first stage
    t_ringMsg         reqQ502H;   // second stage, drives the ring
    logic [CNT_W-1:0] creditCnt;  // free rsp queue entries
    logic             isLocal;
    logic             hasCredit;
    logic             accept;

    // ============================================================
    // stage 1 - sample the ring
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            reqQ501H <= '0;
        end else begin
            reqQ501H <= ringReqIn;
        end
    end

    // addressed to us and a plain request
    assign isLocal = reqQ501H.valid
                  && (reqQ501H.address[`LOTR_CORE_MSB:`LOTR_CORE_LSB] == coreId)
                  && ((reqQ501H.opcode == RD) || (reqQ501H.opcode == WR));
    assign hasCredit = (creditCnt != '0);
    assign accept    = isLocal && hasCredit; // no credit -> goes around again

    assign localReq = accept ? reqQ501H : '0;

    // ============================================================
    // credits
    // ============================================================
    // spend on accept, regain on return, both may hit in one cycle
    always_ff @(posedge QClk) begin
        if (rst) begin
            creditCnt <= CNT_W'(`LOTR_RSP_CREDITS);
        end else begin
            creditCnt <= creditCnt + CNT_W'(creditReturn) - CNT_W'(accept);
        end
    end

    // ============================================================
    // stage 2 - back onto the ring
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            reqQ502H <= '0;
        end else if (accept) begin
            reqQ502H <= '0;        // consumed here, empty slot
        end else begin
            reqQ502H <= reqQ501H;  // forward untouched
        end
    end

    assign ringReqOut = reqQ502H;

    // a return without a matching accept would push past the queue depth
    creditBound: assert property (@(posedge QClk) disable iff (rst)
        creditCnt <= CNT_W'(`LOTR_RSP_CREDITS))
        else $error("credit count above %0d", `LOTR_RSP_CREDITS);

endmodule

// File: src/mmioDevice.sv
// mmio device: six hex digits, LED register, switch/button status, one rsp per req
`include "lotrTile_defines.svh"
module mmioDevice
    import lotrRingPkg::*;
    import lotrMmioPkg::*;
(
    input  logic       QClk,
    input  logic       rst,
    input  t_ringMsg   localReq,  // accepted local request
    input  logic [9:0] switches,
    input  logic [1:0] buttons,
    output t_ringMsg   localRsp,  // one cycle after localReq
    output t_display   display
);

    logic [5:0][3:0] digitReg;  // one nibble per display
    logic [6:0]      ledReg;
    t_mmioReg        regIdx;
    logic            mapped;    // offset inside the register window
    logic            isWrite;
    logic [31:0]     readData;
    t_ringMsg        rspQ502H;

    // ============================================================
    // decode
    // ============================================================
    assign regIdx  = t_mmioReg'(localReq.address[4:2]);
    // bits above the index must be zero, byte offset ignored
    assign mapped  = (localReq.address[`LOTR_CORE_LSB-1:5] == '0);
    assign isWrite = localReq.valid && (localReq.opcode == WR);

    always_comb begin
        readData = '0; // unmapped reads as zero
        if (mapped) begin
            case (regIdx)
                REG_LED:    readData = {25'b0, ledReg};
                REG_STATUS: readData = {20'b0, buttons, switches};
                default:    readData = {28'b0, digitReg[regIdx]}; // digits 0..5
            endcase
        end
    end

    // ============================================================
    // register writes
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            digitReg <= '0;
            ledReg   <= '0;
        end else if (isWrite && mapped) begin
            case (regIdx)
                REG_LED:    ledReg <= localReq.data[6:0];
                REG_STATUS: ;                                    // read only
                default:    digitReg[regIdx] <= localReq.data[3:0];
            endcase
        end
    end

    // ============================================================
    // response
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            rspQ502H <= '0;
        end else begin
            rspQ502H.valid     <= localReq.valid;
            rspQ502H.requestor <= localReq.requestor;   // route back to issuer
            rspQ502H.address   <= localReq.address;
            rspQ502H.opcode    <= (localReq.opcode == WR) ? WR_RSP : RD_RSP;
            rspQ502H.data      <= (localReq.opcode == WR) ? localReq.data : readData;
        end
    end

    assign localRsp = rspQ502H;

    // segments straight from the stored nibbles
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            display.seg[i] = hexToSeg(digitReg[i]);
        end
        display.led = ledReg;
    end

    // filter only hands over plain requests
    reqOpcode: assert property (@(posedge QClk) disable iff (rst)
        localReq.valid |-> (localReq.opcode inside {RD, WR}))
        else $error("mmio got non request opcode %0d", localReq.opcode);

endmodule

// File: src/rspQueue.sv
// local response FIFO, pointer pair plus occupancy count
`include "lotrTile_defines.svh"
module rspQueue
    import lotrRingPkg::*;
(
    input  logic     QClk,
    input  logic     rst,
    input  logic     push,
    input  t_ringMsg pushMsg,
    input  logic     pop,
    output t_ringMsg headMsg,  // valid only when not empty
    output logic     empty
);

    localparam int DEPTH = `LOTR_RSP_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_ringMsg         mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign headMsg = mem[rdPtr];

    // storage
    always_ff @(posedge QClk) begin
        if (push) begin
            mem[wrPtr] <= pushMsg;
        end
    end

    // pointers wrap at DEPTH-1, depth need not be a power of two
    always_ff @(posedge QClk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // credit scheme upstream keeps these from firing
    noOverflow: assert property (@(posedge QClk) disable iff (rst) push |-> !full)
        else $error("push into full rsp queue");
    noUnderflow: assert property (@(posedge QClk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty rsp queue");

endmodule

// File: src/ringRspMerge.sv
// response ring stop: two stage pipe, local responses fill empty slots
module ringRspMerge
    import lotrRingPkg::*;
(
    input  logic     QClk,
    input  logic     rst,
    input  t_ringMsg ringRspIn,
    input  t_ringMsg localRsp,     // from mmio, pushed on valid
    output t_ringMsg ringRspOut,
    output logic     creditReturn  // slot taken by a local rsp
);

    t_ringMsg rspQ501H;
    t_ringMsg rspQ502H;
    t_ringMsg headMsg;
    logic     qEmpty;
    logic     fillSlot;

    rspQueue rspQueue (
        .QClk    (QClk),
        .rst     (rst),
        .push    (localRsp.valid),
        .pushMsg (localRsp),
        .pop     (fillSlot),
        .headMsg (headMsg),
        .empty   (qEmpty)
    );

    // ============================================================
    // stage 1
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            rspQ501H <= '0;
        end else begin
            rspQ501H <= ringRspIn;
        end
    end

    // ring traffic owns the slot, local only fills holes
    assign fillSlot     = !rspQ501H.valid && !qEmpty;
    assign creditReturn = fillSlot;   // entry freed at this edge

    // ============================================================
    // stage 2 - output slot
    // ============================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            rspQ502H <= '0;
        end else if (fillSlot) begin
            rspQ502H <= headMsg;
        end else begin
            rspQ502H <= rspQ501H;     // passthrough or empty slot
        end
    end

    assign ringRspOut = rspQ502H;

endmodule

// File: src/fpgaTile.sv
// ring tile top: request filter, mmio device and response merge
module fpgaTile
    import lotrRingPkg::*;
    import lotrMmioPkg::*;
(
    input  logic       QClk,
    input  logic       rst,
    input  logic [7:0] coreId,
    // ring in
    input  t_ringMsg   ringReqIn,
    input  t_ringMsg   ringRspIn,
    // board inputs
    input  logic [9:0] switches,
    input  logic [1:0] buttons,
    // ring out
    output t_ringMsg   ringReqOut,
    output t_ringMsg   ringRspOut,
    // board outputs
    output t_display   display
);

    t_ringMsg localReq;     // filter -> mmio
    t_ringMsg localRsp;     // mmio -> merge
    logic     creditReturn; // merge -> filter

    // ============================================================
    // request side
    // ============================================================
    ringReqFilter ringReqFilter (
        .QClk         (QClk),
        .rst          (rst),
        .coreId       (coreId),
        .ringReqIn    (ringReqIn),
        .creditReturn (creditReturn),
        .ringReqOut   (ringReqOut),
        .localReq     (localReq)
    );

    mmioDevice mmioDevice (
        .QClk     (QClk),
        .rst      (rst),
        .localReq (localReq),
        .switches (switches),
        .buttons  (buttons),
        .localRsp (localRsp),
        .display  (display)
    );

    // ============================================================
    // response side
    // ============================================================
    ringRspMerge ringRspMerge (
        .QClk         (QClk),
        .rst          (rst),
        .ringRspIn    (ringRspIn),
        .localRsp     (localRsp),
        .ringRspOut   (ringRspOut),
        .creditReturn (creditReturn)
    );

endmodule

// File: dv/fpgaTileTb.sv
// fpgaTile testbench with clock, reset, LFSR stimulus, reference model, assertions, timeout
`include "lotrTile_defines.svh"
module fpgaTileTb
    import lotrRingPkg::*;
    import lotrMmioPkg::*;
();

    localparam int RUN_CYCLES = 5 + 40 + 40 + 40 + 60 + 7 * 4; // reset plus traffic phases
    localparam int LIMIT      = RUN_CYCLES + 150;               // drains fit in the margin

    // active low DE10-Lite patterns {g,f,e,d,c,b,a}
    localparam logic [6:0] segTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic       QClk;
    logic       rst;
    logic [7:0] coreId;
    t_ringMsg   ringReqIn;
    t_ringMsg   ringRspIn;
    logic [9:0] switches;
    logic [1:0] buttons;
    t_ringMsg   ringReqOut;
    t_ringMsg   ringRspOut;
    t_display   display;

    // ============================================================
    // reference model state
    // ============================================================
    logic [31:0]     lfsr = 32'h11e5_229b;
    logic [5:0][3:0] digitM;              // digit nibbles
    logic [6:0]      ledM;
    int              credits;
    int              fwdSeen;             // valid slots seen on ringReqOut
    int              cycleCnt = 0;
    t_ringMsg        lastReqIn;           // driven last cycle and not yet decided
    t_ringMsg        reqDecided;          // decided and leaving next cycle
    t_ringMsg        lastRspIn;
    t_ringMsg        rspD1;
    t_ringMsg        localQ [$];          // expected local rsps in order
    string           testName;

    // captured at falling edge and checked at the next rising edge
    t_ringMsg obsReqOut;
    t_ringMsg obsRspOut;
    t_display obsDisplay;
    t_ringMsg expReqOut;
    t_ringMsg expRspPass;
    t_ringMsg expLocal;
    t_display expDisplay;
    logic     localPending;

    fpgaTile DUT (
        .QClk       (QClk),
        .rst        (rst),
        .coreId     (coreId),
        .ringReqIn  (ringReqIn),
        .ringRspIn  (ringRspIn),
        .switches   (switches),
        .buttons    (buttons),
        .ringReqOut (ringReqOut),
        .ringRspOut (ringRspOut),
        .display    (display)
    );

    initial begin
        QClk = 1'b0;
        forever #50 QClk = ~QClk;
    end

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] otherCore();
        return coreId + 8'd1 + 8'(randBits(7)); // never wraps onto coreId
    endfunction

    function automatic t_ringMsg makeMsg(input logic [7:0] core, input t_opcode op,
                                         input logic [2:0] idx, input logic unmapped);
        t_ringMsg    m;
        logic [18:0] spare;                // address bits 23..5
        spare              = unmapped ? {18'(randBits(18)), 1'b1} : 19'b0;
        m.valid            = 1'b1;
        m.requestor.core   = 8'(randBits(8));
        m.requestor.thread = 2'(randBits(2));
        m.opcode           = op;
        m.address          = {core, spare, idx, 2'(randBits(2))};
        m.data             = randBits(32);
        return m;
    endfunction

    function automatic logic [31:0] readReg(input logic [31:0] addr);
        if (addr[23:5] != '0) begin
            return '0;                     // outside the window
        end
        case (addr[4:2])
            3'(`LOTR_REG_LED):    return {25'b0, ledM};
            3'(`LOTR_REG_STATUS): return {20'b0, buttons, switches};
            default:              return {28'b0, digitM[addr[4:2]]};
        endcase
    endfunction

    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
        if (addr[23:5] == '0) begin
            if (addr[4:2] == 3'(`LOTR_REG_LED)) begin
                ledM = data[6:0];
            end else if (addr[4:2] < 3'(`LOTR_REG_LED)) begin
                digitM[addr[4:2]] = data[3:0];
            end                            // status ignores writes
        end
    endtask

    function automatic t_display modelDisplay();
        t_display d;
        for (int i = 0; i < 6; i++) begin
            d.seg[i] = segTable[digitM[i]];
        end
        d.led = ledM;
        return d;
    endfunction

    // accepted when own core, plain request and a credit left
    task automatic decideReq(input t_ringMsg m, output t_ringMsg fwd);
        t_ringMsg rsp;
        fwd = m;
        if (m.valid && m.address[`LOTR_CORE_MSB:`LOTR_CORE_LSB] == coreId
                && (m.opcode == RD || m.opcode == WR) && credits > 0) begin
            credits--;
            fwd = '0;                      // slot left empty
            rsp = m;                       // requestor and address kept
            if (m.opcode == WR) begin
                rsp.opcode = WR_RSP;       // data echoes the write
                writeReg(m.address, m.data);
            end else begin
                rsp.opcode = RD_RSP;
                rsp.data   = readReg(m.address);
            end
            localQ.push_back(rsp);
        end
    endtask

    // ============================================================
    // each falling edge observes, advances the model and drives
    // ============================================================
    task automatic advanceModel(input t_ringMsg req, input t_ringMsg rsp);
        obsReqOut    = ringReqOut;
        obsRspOut    = ringRspOut;
        obsDisplay   = display;
        if (obsReqOut.valid) begin
            fwdSeen++;
        end
        expRspPass   = rspD1;              // ring rsp from two cycles back
        rspD1        = lastRspIn;
        localPending = (localQ.size() > 0);
        expLocal     = localPending ? localQ[0] : '0;
        if (!expRspPass.valid && obsRspOut.valid && localPending) begin
            void'(localQ.pop_front());     // slot taken so the credit comes back
            credits++;
        end
        expReqOut  = reqDecided;
        expDisplay = modelDisplay();       // writes land after this edge
        // status is captured at the next edge, so new board inputs go first
        switches   = 10'(randBits(10));
        buttons    = 2'(randBits(2));
        decideReq(lastReqIn, reqDecided);
        ringReqIn = req;
        ringRspIn = rsp;
        lastReqIn = req;
        lastRspIn = rsp;
    endtask

    task automatic driveCycle(input t_ringMsg req, input t_ringMsg rsp);
        @(negedge QClk);
        advanceModel(req, rsp);
    endtask

    task automatic runTraffic(input string name, input int cycles,
                              input logic allowWr, input logic allowRd);
        t_ringMsg req;
        t_ringMsg rsp;
        t_opcode  op;
        testName = name;
        for (int i = 0; i < cycles; i++) begin
            req = '0;
            rsp = '0;
            if ((allowWr || allowRd) && randBits(2) != 0) begin
                op  = (allowRd && !(allowWr && randBits(1))) ? RD : WR;
                req = makeMsg(coreId, op, 3'(randBits(3)), randBits(3) == 0);
            end else if (randBits(1)) begin
                op  = t_opcode'(2'(randBits(2)));
                // rsp opcodes may name this core and still pass
                req = makeMsg((op inside {RD_RSP, WR_RSP}) ? coreId : otherCore(), op,
                              3'(randBits(3)), 1'b0);
            end
            if (randBits(1)) begin
                rsp = makeMsg(otherCore(), t_opcode'({1'b1, 1'(randBits(1))}),
                              3'(randBits(3)), 1'b0);
            end
            driveCycle(req, rsp);
        end
    endtask

    task automatic drain();
        repeat (3) driveCycle('0, '0);
        while (localQ.size() != 0) begin
            driveCycle('0, '0);
        end
        repeat (3) driveCycle('0, '0);     // flush both pipes
    endtask

    // rsp ring full every cycle so no slot frees a credit
    task automatic backPressure();
        int       fwdBase;
        t_ringMsg req;
        testName = "backPressure";
        drain();
        fwdBase = fwdSeen;
        for (int i = 0; i < 7; i++) begin
            req = makeMsg(coreId, randBits(1) ? RD : WR, 3'(randBits(3)), 1'b0);
            driveCycle(req, makeMsg(otherCore(), RD_RSP, 3'(randBits(3)), 1'b0));
            repeat (3) driveCycle('0, makeMsg(otherCore(), WR_RSP, 3'(randBits(3)), 1'b0));
        end
        // every request not seen again on the ring was taken by the tile
        acceptedCount: assert (7 - (fwdSeen - fwdBase) == `LOTR_RSP_CREDITS)
            else reportMismatch("accepted requests", `LOTR_RSP_CREDITS,
                                7 - (fwdSeen - fwdBase));
        drain();
    endtask

    task automatic reportMismatch(input string what, input logic [127:0] expected,
                                  input logic [127:0] actual);
        $display("ERROR test %s, %s: expected %h, actual %h", testName, what, expected,
                 actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "check failed");
    endtask

    // ============================================================
    // checks
    // ============================================================
    reqOutCheck: assert property (@(posedge QClk) disable iff (rst) obsReqOut == expReqOut)
        else reportMismatch("ringReqOut", expReqOut, obsReqOut);
    rspPassCheck: assert property (@(posedge QClk) disable iff (rst)
        expRspPass.valid |-> (obsRspOut == expRspPass))
        else reportMismatch("ringRspOut passthrough", expRspPass, obsRspOut);
    // a local rsp only in a free slot, and in request order
    rspLocalCheck: assert property (@(posedge QClk) disable iff (rst)
        (!expRspPass.valid && obsRspOut.valid) |-> (localPending && obsRspOut == expLocal))
        else reportMismatch("local response", expLocal, obsRspOut);
    displayCheck: assert property (@(posedge QClk) disable iff (rst) obsDisplay == expDisplay)
        else reportMismatch("display", expDisplay, obsDisplay);

    always @(posedge QClk) begin
        cycleCnt++;
        if (cycleCnt > LIMIT) begin
            $display("timeout: run still going after %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst        = 1'b1;
        coreId     = 8'h5a;
        ringReqIn  = '0;
        ringRspIn  = '0;
        switches   = '0;
        buttons    = '0;
        digitM     = '0;
        ledM       = '0;
        credits    = `LOTR_RSP_CREDITS;
        fwdSeen    = 0;
        lastReqIn  = '0;
        reqDecided = '0;
        lastRspIn  = '0;
        rspD1      = '0;
        testName   = "reset";
        repeat (5) @(negedge QClk);
        rst = 1'b0;
        advanceModel('0, '0);              // first check sees reset state
        runTraffic("passthrough", 40, 1'b0, 1'b0);
        runTraffic("regWrite", 40, 1'b1, 1'b0);
        runTraffic("regRead", 40, 1'b0, 1'b1);
        runTraffic("localSlot", 60, 1'b1, 1'b1);
        backPressure();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/lotrRingPkg.sv
src/lotrMmioPkg.sv
src/ringReqFilter.sv
src/mmioDevice.sv
src/rspQueue.sv
src/ringRspMerge.sv
src/fpgaTile.sv
dv/fpgaTileTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fpgaTile testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fpgaTileTb \
    -f compile.f -o simTile
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simTile 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
